//--- all.f
+incdir+include
logic/dmacPkg.sv
logic/fifoIf.sv
logic/scsiPacker.sv
logic/dmaFifo.sv
logic/cpuBusMaster.sv
logic/scsiDma.sv
sim/scsiDma_assertions.sv
sim/busChecker.sv
sim/scsiDma_tb.sv

//--- include/dmac_config.svh
// build-time sizes for the SCSI DMA; FIFO depth must be a power of two, data bus fixed at 32 bits
`ifndef DMAC_CONFIG_SVH
`define DMAC_CONFIG_SVH

// width of one FIFO word and of the processor data bus
`define DMAC_WORD_BITS 32

// longwords held by the FIFO, a power of two
`define DMAC_FIFO_DEPTH 8

// occupancy at which the bus master requests the bus
`define DMAC_BURST_WORDS 4

`endif

//--- logic/cpuBusMaster.sv
// FIFO-to-memory bus master; 32- and 16-bit ports only, dsack 01 is taken as a wait state
`include "dmac_config.svh"

module cpuBusMaster import dmacPkg::*; (
    input  logic                       CLK,
    input  logic                       nRESET,
    fifoIf.reader                      rd,
    input  logic                       dmaStart,
    input  logic [31:0]                dmaAddr,
    input  logic                       bgrant,
    input  logic [1:0]                 dsack,
    input  logic                       sterm,
    output logic                       breq,
    output logic                       bgack,
    output logic                       pas,
    output logic                       pds,
    output logic                       size16,
    output logic                       dmaDone,
    output logic [31:0]                addr,
    output logic [`DMAC_WORD_BITS-1:0] dataOut
);

    localparam int HALF_BITS = `DMAC_WORD_BITS / 2;

    typedef enum logic [1:0] {
        TERM_WAIT,                                  // no termination yet
        TERM_16,                                    // 16-bit dsack
        TERM_32                                     // 32-bit dsack or sterm
    } termKind_t;

    busState_t   state;
    busState_t   nextState;
    termKind_t   term;
    logic [31:0] addrCnt;                           // address of the head word
    logic        lastPopped;                        // transfer's final word has gone out
    logic        wordDone;
    logic        halfPhase;

    // sterm takes priority, it always means a full longword
    always_comb begin
        if (sterm) begin
            term = TERM_32;
        end else if (dsack == 2'b11) begin
            term = TERM_32;
        end else if (dsack == 2'b10) begin
            term = TERM_16;
        end else begin
            term = TERM_WAIT;
        end
    end

    assign wordDone  = (state == DATA && term == TERM_32)
                    || (state == HALF_DATA && term != TERM_WAIT);
    assign halfPhase = state == HALF_ADDR || state == HALF_DATA;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (rd.count >= fifoCount_t'(`DMAC_BURST_WORDS) || rd.lastHeld) begin
                    nextState = BUS_REQ;
                end
            end
            BUS_REQ: begin
                if (bgrant) begin
                    nextState = BUS_ACK;
                end
            end
            BUS_ACK: begin
                if (lastPopped || rd.empty) begin
                    nextState = CYCLE_END;          // give the bus back
                end else begin
                    nextState = ADDR;
                end
            end
            ADDR: nextState = DATA;
            DATA: begin
                case (term)
                    TERM_32: nextState = BUS_ACK;
                    TERM_16: nextState = HALF_ADDR; // port too narrow, send the lower half
                    default: nextState = DATA;      // wait state
                endcase
            end
            HALF_ADDR: nextState = HALF_DATA;
            HALF_DATA: begin
                if (term != TERM_WAIT) begin
                    nextState = BUS_ACK;
                end
            end
            CYCLE_END: nextState = IDLE;
            default:   nextState = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state      <= IDLE;
            addrCnt    <= '0;
            lastPopped <= 1'b0;
        end else begin
            state <= nextState;
            if (dmaStart) begin
                addrCnt <= dmaAddr;
            end else if (wordDone) begin
                addrCnt <= addrCnt + 32'd4;
            end
            if (state == CYCLE_END) begin
                lastPopped <= 1'b0;
            end else if (wordDone && rd.head.lastWord) begin
                lastPopped <= 1'b1;
            end
        end
    end

    assign rd.pop = wordDone;                       // head advances at the terminating edge

    assign breq    = state == BUS_REQ;
    assign bgack   = state inside {BUS_ACK, ADDR, DATA, HALF_ADDR, HALF_DATA};
    assign pas     = state inside {ADDR, DATA, HALF_ADDR, HALF_DATA};
    assign pds     = state == DATA || state == HALF_DATA;
    assign size16  = halfPhase;
    assign dmaDone = state == CYCLE_END && lastPopped;

    assign addr    = halfPhase ? addrCnt + 32'd2 : addrCnt;
    // lower half goes out on both lanes of a 16-bit port
    assign dataOut = halfPhase ? {2{rd.head.data[HALF_BITS-1:0]}} : rd.head.data;

endmodule

//--- logic/dmaFifo.sv
// show-ahead longword FIFO; depth from DMAC_FIFO_DEPTH, illegal push or pop is ignored
`include "dmac_config.svh"

module dmaFifo import dmacPkg::*; (
    input  logic    CLK,
    input  logic    nRESET,
    fifoIf.fifoSide wr,
    fifoIf.fifoSide rd
);

    localparam int PTR_BITS = $clog2(`DMAC_FIFO_DEPTH);

    fifoWord_t           mem [`DMAC_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    fifoCount_t          occupancy;
    fifoCount_t          lastCount;                 // stored words with lastWord set
    fifoWord_t           headWord;
    logic                isFull;
    logic                isEmpty;
    logic                doPush;
    logic                doPop;

    assign isFull   = occupancy == fifoCount_t'(`DMAC_FIFO_DEPTH);
    assign isEmpty  = occupancy == '0;
    assign doPush   = wr.push && !isFull;
    assign doPop    = rd.pop && !isEmpty;
    assign headWord = mem[rdPtr];                   // oldest entry, no read latency

    always_ff @(posedge CLK) begin
        if (doPush) begin
            mem[wrPtr] <= wr.wrWord;
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
            lastCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;              // wraps, depth is a power of two
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            occupancy <= occupancy + fifoCount_t'(doPush) - fifoCount_t'(doPop);
            lastCount <= lastCount + fifoCount_t'(doPush && wr.wrWord.lastWord)
                                   - fifoCount_t'(doPop && headWord.lastWord);
        end
    end

    // both ports see the same state
    assign wr.full     = isFull;
    assign wr.head     = headWord;
    assign wr.empty    = isEmpty;
    assign wr.count    = occupancy;
    assign wr.lastHeld = lastCount != '0;
    assign rd.full     = isFull;
    assign rd.head     = headWord;
    assign rd.empty    = isEmpty;
    assign rd.count    = occupancy;
    assign rd.lastHeld = lastCount != '0;

endmodule

//--- logic/dmacPkg.sv
// types shared by the DMA blocks; the widths come from dmac_config.svh
`include "dmac_config.svh"

package dmacPkg;

    typedef struct packed {
        logic [`DMAC_WORD_BITS-1:0] data;           // big-endian longword
        logic                       lastWord;       // final word of a transfer
    } fifoWord_t;

    // occupancy, one bit wider than the pointers so a full FIFO fits
    typedef logic [$clog2(`DMAC_FIFO_DEPTH):0] fifoCount_t;

    typedef enum logic [2:0] {
        IDLE,                                       // waiting for a burst
        BUS_REQ,                                    // breq out, waiting for bgrant
        BUS_ACK,                                    // bus owned, no cycle running
        ADDR,                                       // address phase
        DATA,                                       // data phase, waiting for termination
        HALF_ADDR,                                  // second half on a 16-bit port
        HALF_DATA,
        CYCLE_END                                   // bgack released
    } busState_t;

endpackage

//--- logic/fifoIf.sv
// FIFO push/pop channel; push while full and pop while empty are not allowed
interface fifoIf import dmacPkg::*; ();

    logic       push;                               // from the writer
    fifoWord_t  wrWord;
    logic       full;                               // from the FIFO
    fifoWord_t  head;                               // oldest word, always shown
    logic       empty;
    logic       pop;                                // from the reader
    fifoCount_t count;
    logic       lastHeld;                           // a lastWord is stored somewhere

    modport writer (
        output push, wrWord,
        input  full
    );

    modport fifoSide (
        input  push, wrWord, pop,
        output full, head, empty, count, lastHeld
    );

    modport reader (
        output pop,
        input  head, empty, count, lastHeld
    );

endinterface

//--- logic/scsiDma.sv
// SCSI-to-memory DMA top; one direction only, no host register file or FIFO flush
`include "dmac_config.svh"

module scsiDma (
    input  logic                       CLK,
    input  logic                       nRESET,
    input  logic                       scsiStrobe,
    input  logic [7:0]                 scsiByte,
    input  logic                       scsiLast,
    output logic                       scsiHold,
    input  logic                       dmaStart,
    input  logic [31:0]                dmaAddr,
    input  logic                       bgrant,
    input  logic [1:0]                 dsack,
    input  logic                       sterm,
    output logic                       breq,
    output logic                       bgack,
    output logic                       pas,
    output logic                       pds,
    output logic                       size16,
    output logic [31:0]                addr,
    output logic [`DMAC_WORD_BITS-1:0] dataOut,
    output logic                       dmaDone
);

    fifoIf packToFifo ();                           // packer write side
    fifoIf fifoToBus ();                            // bus master read side

    scsiPacker scsiPacker_inst (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .scsiStrobe (scsiStrobe),
        .scsiByte   (scsiByte),
        .scsiLast   (scsiLast),
        .scsiHold   (scsiHold),
        .wr         (packToFifo.writer)
    );

    dmaFifo dmaFifo_inst (
        .CLK    (CLK),
        .nRESET (nRESET),
        .wr     (packToFifo.fifoSide),
        .rd     (fifoToBus.fifoSide)
    );

    cpuBusMaster cpuBusMaster_inst (
        .CLK      (CLK),
        .nRESET   (nRESET),
        .rd       (fifoToBus.reader),
        .dmaStart (dmaStart),
        .dmaAddr  (dmaAddr),
        .bgrant   (bgrant),
        .dsack    (dsack),
        .sterm    (sterm),
        .breq     (breq),
        .bgack    (bgack),
        .pas      (pas),
        .pds      (pds),
        .size16   (size16),
        .dmaDone  (dmaDone),
        .addr     (addr),
        .dataOut  (dataOut)
    );

endmodule

//--- logic/scsiPacker.sv
// packs SCSI bytes MSB first into longwords; the source must stop strobing while scsiHold is high
`include "dmac_config.svh"

module scsiPacker import dmacPkg::*; (
    input  logic       CLK,
    input  logic       nRESET,
    input  logic       scsiStrobe,
    input  logic [7:0] scsiByte,
    input  logic       scsiLast,
    output logic       scsiHold,
    fifoIf.writer      wr
);

    localparam int LANES     = `DMAC_WORD_BITS / 8;
    localparam int LANE_BITS = $clog2(LANES);

    logic [LANE_BITS-1:0]       lane;               // next byte position
    logic [`DMAC_WORD_BITS-1:0] accWord;            // partly filled longword
    logic [`DMAC_WORD_BITS-1:0] nextWord;
    fifoWord_t                  holdWord;           // finished word waiting for the FIFO
    logic                       holdValid;
    logic                       wordComplete;

    // drop the incoming byte into its lane, lane 0 is the top byte
    always_comb begin
        nextWord = accWord;
        nextWord[(LANES - 1 - int'(lane)) * 8 +: 8] = scsiByte;
    end

    assign wordComplete = scsiStrobe && (lane == LANE_BITS'(LANES - 1) || scsiLast);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            lane      <= '0;
            accWord   <= '0;
            holdValid <= 1'b0;
        end else begin
            if (scsiStrobe) begin
                if (wordComplete) begin
                    lane    <= '0;
                    accWord <= '0;                  // unfilled lanes of a short word stay zero
                end else begin
                    lane    <= lane + 1'b1;
                    accWord <= nextWord;
                end
            end
            if (wordComplete) begin
                holdValid <= 1'b1;                  // reload wins over a push on the same edge
            end else if (wr.push) begin
                holdValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wordComplete) begin
            holdWord <= '{data: nextWord, lastWord: scsiLast};
        end
    end

    assign wr.push   = holdValid && !wr.full;
    assign wr.wrWord = holdWord;
    assign scsiHold  = holdValid && wr.full;        // word stuck until the FIFO drains

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module scsiDma_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VscsiDma_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim/busChecker.sv
// predicts each terminated bus cycle from the bytes sent; one transfer in flight at a time
`include "dmac_config.svh"

module busChecker (
    input  logic        CLK,
    input  logic        nRESET,
    input  logic        scsiStrobe,
    input  logic        scsiLast,
    input  logic        breq,
    input  logic        bgack,
    input  logic        pas,
    input  logic        pds,
    input  logic        size16,
    input  logic [1:0]  dsack,
    input  logic        sterm,
    input  logic [31:0] addr,
    input  logic [31:0] dataOut,
    input  logic        dmaDone,
    output int          errors
);

    logic [7:0]  expBytes[$];                       // sent, not yet seen on the bus
    string       testName = "none";
    logic [31:0] startAddr = '0;
    logic [31:0] expWord;
    int          errCount = 0;
    int          wordIdx = 0;
    int          strobed = 0;
    int          doneCount = 0;
    bit          lastArrived = 1'b0;
    bit          lastSent = 1'b0;                   // final word terminated
    bit          halfPending = 1'b0;                // upper half already written
    bit          breqSeen = 1'b0;
    bit          prevBgack = 1'b0;

    assign errors = errCount;

    task automatic queueByte(input logic [7:0] b);
        expBytes.push_back(b);
    endtask

    task automatic startTest(input string name, input logic [31:0] start);
        testName    = name;
        startAddr   = start;
        wordIdx     = 0;
        strobed     = 0;
        doneCount   = 0;
        lastArrived = 1'b0;
        lastSent    = 1'b0;
        halfPending = 1'b0;
        breqSeen    = 1'b0;
        expBytes.delete();
    endtask

    task automatic finishTest();
        if (expBytes.size() != 0) begin
            $display("test %s: %0d bytes never appeared on the bus", testName, expBytes.size());
            errCount++;
        end
        if (doneCount != 1) begin
            $display("test %s: dmaDone pulsed %0d times, once expected", testName, doneCount);
            errCount++;
        end
    endtask

    // first byte on top, missing bytes of a short word are zero
    function automatic logic [31:0] nextWord();
        logic [31:0] w;
        int          i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            w = w << 8;
            if (i < expBytes.size()) begin
                w[7:0] = expBytes[i];
            end
        end
        return w;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h actual %h", testName, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic retireWord();
        int i;
        for (i = 0; i < 4 && expBytes.size() > 0; i++) begin
            void'(expBytes.pop_front());
        end
        wordIdx++;
        lastSent = lastArrived && expBytes.size() == 0;
    endtask

    always @(posedge CLK) begin
        if (nRESET) begin
            if (scsiStrobe) begin
                strobed++;
                lastArrived = lastArrived || scsiLast;
            end
            breqSeen = breqSeen || breq;
            if (bgack && !prevBgack) begin
                if (!breqSeen) begin
                    $display("test %s: bus tenure began without breq", testName);
                    errCount++;
                end
                if (!lastArrived && strobed - 4 * wordIdx < 4 * `DMAC_BURST_WORDS) begin
                    $display("test %s: bus tenure began before a burst was buffered", testName);
                    errCount++;
                end
                breqSeen = 1'b0;
            end
            prevBgack = bgack;
            if (pas && (!bgack || lastSent)) begin
                $display("test %s: pas without bgack or after the last word", testName);
                errCount++;
            end
            if (dmaDone) begin
                doneCount++;
                if (!lastSent) begin
                    $display("test %s: dmaDone before the last word was written", testName);
                    errCount++;
                end
            end
            if (pds && (sterm || dsack == 2'b11 || dsack == 2'b10)) begin
                if (expBytes.size() == 0) begin
                    $display("test %s: bus cycle with no data left to write", testName);
                    errCount++;
                end
                expWord = nextWord();
                if (halfPending) begin                  // second half, 16-bit port
                    compare("addr", startAddr + 32'(4 * wordIdx) + 32'd2, addr);
                    compare("size16", 32'd1, 32'(size16));
                    compare("lower half", {16'h0, expWord[15:0]}, {16'h0, dataOut[31:16]});
                    halfPending = 1'b0;
                    retireWord();
                end else begin
                    compare("addr", startAddr + 32'(4 * wordIdx), addr);
                    compare("size16", 32'd0, 32'(size16));
                    if (!sterm && dsack == 2'b10) begin
                        compare("upper half", {16'h0, expWord[31:16]}, {16'h0, dataOut[31:16]});
                        halfPending = 1'b1;
                    end else begin
                        compare("data", expWord, dataOut);
                        retireWord();
                    end
                end
            end
        end
    end

endmodule

//--- sim/dma_input.txt
# name  startAddr(hex)  byteCount  portKind(0 dsack32, 1 dsack16, 2 sterm)  grantDelay(cycles)
# one transfer per line, run in order
dsack32_basic   00001000  32  0  2
sterm_basic     00002000  24  2  1
dsack16_basic   00003000  16  1  3
partial_last    00004000  13  0  0
partial_16bit   00005000   7  1  2
single_byte     00007000   1  2  0
backpressure    00006000  48  0  80
sterm_partial   00008000  30  2  5
dsack16_long    0000a000  36  1  1

//--- sim/scsiDma_assertions.sv
// bound into cpuBusMaster; reset must be low at time zero, checks sample at rising edges only
`include "dmac_config.svh"

module scsiDmaAssertions import dmacPkg::*; (
    input logic                       CLK,
    input logic                       nRESET,
    input logic                       bgrant,
    input logic                       bgack,
    input logic                       pas,
    input logic                       pds,
    input logic [31:0]                addr,
    input logic [`DMAC_WORD_BITS-1:0] dataOut,
    input busState_t                  state
);

    pasNeedsBgack: assert property (@(posedge CLK) disable iff (!nRESET) pas |-> bgack)
        else $error("pas high while bgack is low");

    bgackNeedsGrant: assert property (@(posedge CLK) disable iff (!nRESET)
        $rose(bgack) |-> $past(bgrant))
        else $error("bgack rose without bgrant");

    pdsNeedsPas: assert property (@(posedge CLK) disable iff (!nRESET) pds |-> pas)
        else $error("pds high while pas is low");

    // address and data hold still while the slave inserts wait states
    dataPhaseStable: assert property (@(posedge CLK) disable iff (!nRESET)
        state inside {DATA, HALF_DATA} |-> $stable(addr) && $stable(dataOut))
        else $error("addr or dataOut changed during a data phase");

endmodule

bind cpuBusMaster scsiDmaAssertions scsiDmaAssertions_inst (
    .CLK     (CLK),
    .nRESET  (nRESET),
    .bgrant  (bgrant),
    .bgack   (bgack),
    .pas     (pas),
    .pds     (pds),
    .addr    (addr),
    .dataOut (dataOut),
    .state   (state)
);

//--- sim/scsiDma_tb.sv
// runs the transfers listed in sim/dma_input.txt in order; the slave adds one wait state per cycle
`include "dmac_config.svh"

module scsiDma_tb;

    logic        CLK = 1'b0;
    logic        nRESET;
    logic        scsiStrobe;
    logic [7:0]  scsiByte;
    logic        scsiLast;
    logic        scsiHold;
    logic        dmaStart;
    logic [31:0] dmaAddr;
    logic        bgrant = 1'b0;
    logic [1:0]  dsack = 2'b00;
    logic        sterm = 1'b0;
    logic        breq, bgack, pas, pds, size16, dmaDone;
    logic [31:0] addr;
    logic [31:0] dataOut;

    integer      seed = 32'h9c52_03f2;
    string       names[$];
    logic [31:0] starts[$];
    int          counts[$];
    int          kinds[$];
    int          delays[$];
    int          portKind = 0;                      // 0 dsack32, 1 dsack16, 2 sterm
    int          grantDelay = 0;
    int          grantWait = 0;
    bit          waitDone = 1'b0;                   // wait state already inserted
    bit          holdSeen;
    int          tbErrors = 0;
    int          checkErrors;
    int          cycles = 0;
    int          cycleLimit = 0;

    always #20 CLK = ~CLK;

    scsiDma scsiDma_inst (.*);

    busChecker checkInst (.errors(checkErrors), .*);

    // arbiter, grant after grantDelay cycles of breq, kept for the whole tenure
    always @(negedge CLK) begin
        if (!breq && !bgack) begin
            bgrant    <= 1'b0;
            grantWait <= 0;
        end else if (breq && !bgrant) begin
            if (grantWait >= grantDelay) begin
                bgrant <= 1'b1;
            end else begin
                grantWait <= grantWait + 1;
            end
        end
    end

    // memory slave
    always @(negedge CLK) begin
        if (!pds) begin
            dsack    <= 2'b00;
            sterm    <= 1'b0;
            waitDone <= 1'b0;
        end else if (!waitDone) begin
            waitDone <= 1'b1;
        end else begin
            case (portKind)
                0:       dsack <= 2'b11;
                1:       dsack <= 2'b10;
                default: sterm <= 1'b1;
            endcase
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout: tests not finished after %0d cycles", cycles);
            $display("errors: checker %0d, testbench %0d, timeout 1", checkErrors, tbErrors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic readTests();
        int          fd;
        string       line;
        string       name;
        logic [31:0] start;
        int          count;
        int          kind;
        int          delay;
        cycleLimit = 10;                            // reset cycles
        fd = $fopen("sim/dma_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/dma_input.txt");
            tbErrors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#"
                && $sscanf(line, "%s %h %d %d %d", name, start, count, kind, delay) == 5) begin
                names.push_back(name);
                starts.push_back(start);
                counts.push_back(count);
                kinds.push_back(kind);
                delays.push_back(delay);
                cycleLimit += 20 * count + 200;
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            $display("no tests found in sim/dma_input.txt");
            tbErrors++;
        end
    endtask

    task automatic runTest(input int t);
        int         i;
        logic [7:0] b;
        @(negedge CLK);
        portKind   = kinds[t];
        grantDelay = delays[t];
        holdSeen   = 1'b0;
        dmaAddr    = starts[t];
        dmaStart   = 1'b1;
        checkInst.startTest(names[t], starts[t]);
        @(negedge CLK);
        dmaStart = 1'b0;
        for (i = 0; i < counts[t]; i++) begin
            @(negedge CLK);
            while (scsiHold) begin                  // source pauses while the FIFO is full
                holdSeen = 1'b1;
                @(negedge CLK);
            end
            b          = 8'($random(seed));
            scsiByte   = b;
            scsiLast   = i == counts[t] - 1;
            scsiStrobe = 1'b1;
            checkInst.queueByte(b);
            @(negedge CLK);
            scsiStrobe = 1'b0;
            scsiLast   = 1'b0;
        end
        while (!dmaDone) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);                  // bus must stay quiet after the last word
        checkInst.finishTest();
        if (counts[t] > 4 * (`DMAC_FIFO_DEPTH + 1) && delays[t] > 40 && !holdSeen) begin
            $display("test %s: scsiHold never rose while the bus was withheld", names[t]);
            tbErrors++;
        end
    endtask

    initial begin
        int t;
        nRESET     = 1'b0;
        scsiStrobe = 1'b0;
        scsiByte   = 8'h00;
        scsiLast   = 1'b0;
        dmaStart   = 1'b0;
        dmaAddr    = '0;
        readTests();
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRESET = 1'b1;
        for (t = 0; t < names.size(); t++) begin
            runTest(t);
        end
        $display("errors: checker %0d, testbench %0d, timeout 0", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
